// ==== include/addrgen_defs.svh ====
`ifndef ADDRGEN_DEFS_SVH
`define ADDRGEN_DEFS_SVH

// datapath widths
`define ADDRGEN_ADDR_W    32 // address and APB data width
`define ADDRGEN_STEP      4  // bytes per word
`define ADDRGEN_CNT_W     10 // word, line and feature counters
`define ADDRGEN_TRANS_W   16 // transaction counter
`define ADDRGEN_STRIDE_W  16 // signed line / feature strides

// APB side
`define ADDRGEN_APB_AW    8

// register map, byte offsets
`define ADDRGEN_OFF_BASE         8'h00
`define ADDRGEN_OFF_TRANS        8'h04
`define ADDRGEN_OFF_LINE_STRIDE  8'h08
`define ADDRGEN_OFF_LINE_LEN     8'h0C
`define ADDRGEN_OFF_FEAT_STRIDE  8'h10
`define ADDRGEN_OFF_FEAT_LEN     8'h14
`define ADDRGEN_OFF_FEAT_ROLL    8'h18
`define ADDRGEN_OFF_CTRL         8'h1C
`define ADDRGEN_OFF_STATUS       8'h20

// CTRL register bits
`define ADDRGEN_CTRL_OUTER_BIT   0 // stored
`define ADDRGEN_CTRL_START_BIT   1 // self clearing, write only

`endif

// ==== design/addrgen_reg_pkg.sv ====
`include "addrgen_defs.svh"

package addrgen_reg_pkg;

  // configuration as seen by the tracker and the walker
  typedef struct packed {
    logic        [`ADDRGEN_ADDR_W-1:0]   base_addr;   // byte address, word aligned
    logic        [`ADDRGEN_TRANS_W-1:0]  trans_size;  // total steps
    logic signed [`ADDRGEN_STRIDE_W-1:0] line_stride; // bytes between lines
    logic        [`ADDRGEN_CNT_W-1:0]    line_length; // words per line, >= 1
    logic signed [`ADDRGEN_STRIDE_W-1:0] feat_stride; // bytes between features
    logic        [`ADDRGEN_CNT_W-1:0]    feat_length; // lines per feature, >= 1
    logic        [`ADDRGEN_CNT_W-1:0]    feat_roll;   // roll count, >= 1
    logic                                loop_outer;  // 1 outer, 0 inner feature loop
  } addrgen_cfg_t;

  // APB register offsets
  typedef enum logic [`ADDRGEN_APB_AW-1:0] {
    REG_BASE        = `ADDRGEN_OFF_BASE,
    REG_TRANS       = `ADDRGEN_OFF_TRANS,
    REG_LINE_STRIDE = `ADDRGEN_OFF_LINE_STRIDE,
    REG_LINE_LEN    = `ADDRGEN_OFF_LINE_LEN,
    REG_FEAT_STRIDE = `ADDRGEN_OFF_FEAT_STRIDE,
    REG_FEAT_LEN    = `ADDRGEN_OFF_FEAT_LEN,
    REG_FEAT_ROLL   = `ADDRGEN_OFF_FEAT_ROLL,
    REG_CTRL        = `ADDRGEN_OFF_CTRL,   // outer bit + start command
    REG_STATUS      = `ADDRGEN_OFF_STATUS  // read only
  } addrgen_reg_e;

endpackage

// ==== design/addrgen_loop_pkg.sv ====
`include "addrgen_defs.svh"

package addrgen_loop_pkg;

  // what a single step does to the loop nest
  typedef enum logic [2:0] {
    STEP_IDLE,      // no step this cycle
    STEP_WORD,      // next word in the line
    STEP_LINE,      // next line in the feature
    STEP_FEAT_ADV,  // feature offset moves by feat_stride
    STEP_FEAT_HOLD, // outer mode, feature index only
    STEP_WRAP       // inner mode, everything back to zero
  } addrgen_step_e;

  // walker position inside the three loops
  typedef struct packed {
    logic [`ADDRGEN_CNT_W-1:0]  word_idx;
    logic [`ADDRGEN_CNT_W-1:0]  line_idx;
    logic [`ADDRGEN_CNT_W-1:0]  feat_idx;
    logic [`ADDRGEN_ADDR_W-1:0] line_off; // sum of line strides so far
    logic [`ADDRGEN_ADDR_W-1:0] feat_off; // sum of feature strides so far
  } addrgen_pos_t;

  // flags seen by the consumer
  typedef struct packed {
    logic word_update;
    logic line_update;
    logic feat_update;
    logic in_progress;
  } addrgen_flags_t;

endpackage

// ==== design/addrgen_apb_regs.sv ====
`timescale 1ns/100ps
`include "addrgen_defs.svh"

module addrgen_apb_regs (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // APB3 slave
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [`ADDRGEN_APB_AW-1:0]    paddr_i,
  input  logic [`ADDRGEN_ADDR_W-1:0]    pwdata_i,
  output logic [`ADDRGEN_ADDR_W-1:0]    prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  // to and from the datapath
  input  logic                          in_progress_i,
  output addrgen_reg_pkg::addrgen_cfg_t cfg_o,
  output logic                          start_o
);

  import addrgen_reg_pkg::*;

  addrgen_cfg_t               cfg_q;
  logic                       access;     // APB access phase
  logic                       wr_access;
  logic                       addr_valid; // offset is mapped
  logic [`ADDRGEN_ADDR_W-1:0] rdata;

  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;

  // decode + read mux
  always_comb begin
    addr_valid = 1'b1;
    rdata      = '0;
    case (paddr_i)
      REG_BASE:        rdata = cfg_q.base_addr;
      REG_TRANS:       rdata = `ADDRGEN_ADDR_W'(cfg_q.trans_size);
      REG_LINE_STRIDE: begin
        // sign extended so a negative stride reads back as written
        rdata = {{(`ADDRGEN_ADDR_W-`ADDRGEN_STRIDE_W){cfg_q.line_stride[`ADDRGEN_STRIDE_W-1]}},
                 cfg_q.line_stride};
      end
      REG_LINE_LEN:    rdata = `ADDRGEN_ADDR_W'(cfg_q.line_length);
      REG_FEAT_STRIDE: begin
        rdata = {{(`ADDRGEN_ADDR_W-`ADDRGEN_STRIDE_W){cfg_q.feat_stride[`ADDRGEN_STRIDE_W-1]}},
                 cfg_q.feat_stride};
      end
      REG_FEAT_LEN:    rdata = `ADDRGEN_ADDR_W'(cfg_q.feat_length);
      REG_FEAT_ROLL:   rdata = `ADDRGEN_ADDR_W'(cfg_q.feat_roll);
      REG_CTRL:        rdata = `ADDRGEN_ADDR_W'(cfg_q.loop_outer); // start bit reads 0
      REG_STATUS:      rdata = `ADDRGEN_ADDR_W'(in_progress_i);
      default:         addr_valid = 1'b0;
    endcase
  end

  assign prdata_o  = (access & ~pwrite_i) ? rdata : '0; // quiet bus outside reads
  assign pready_o  = 1'b1;                              // zero wait state
  // unmapped offset or write to read-only status
  assign pslverr_o = access & (~addr_valid | (pwrite_i & (paddr_i == REG_STATUS)));

  // start command pulses for the write cycle only, never stored
  assign start_o = wr_access & (paddr_i == REG_CTRL) & pwdata_i[`ADDRGEN_CTRL_START_BIT];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr_access) begin
      case (paddr_i)
        REG_BASE:        cfg_q.base_addr   <= pwdata_i;
        REG_TRANS:       cfg_q.trans_size  <= pwdata_i[`ADDRGEN_TRANS_W-1:0];
        REG_LINE_STRIDE: cfg_q.line_stride <= pwdata_i[`ADDRGEN_STRIDE_W-1:0];
        REG_LINE_LEN:    cfg_q.line_length <= pwdata_i[`ADDRGEN_CNT_W-1:0];
        REG_FEAT_STRIDE: cfg_q.feat_stride <= pwdata_i[`ADDRGEN_STRIDE_W-1:0];
        REG_FEAT_LEN:    cfg_q.feat_length <= pwdata_i[`ADDRGEN_CNT_W-1:0];
        REG_FEAT_ROLL:   cfg_q.feat_roll   <= pwdata_i[`ADDRGEN_CNT_W-1:0];
        REG_CTRL:        cfg_q.loop_outer  <= pwdata_i[`ADDRGEN_CTRL_OUTER_BIT];
        default:         cfg_q <= cfg_q; // status and holes ignore writes
      endcase
    end
  end

  assign cfg_o = cfg_q;

  // software must wait for the running transfer before restarting
  a_no_start_in_progress : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start_o |-> !in_progress_i
  ) else $error("start command while a transfer is in progress");

  // walker has no byte strobes, so every stride must land on a word
  a_aligned_on_start : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start_o |-> ((cfg_q.base_addr % `ADDRGEN_STEP) == 0) &&
                ((cfg_q.line_stride % `ADDRGEN_STEP) == 0) &&
                ((cfg_q.feat_stride % `ADDRGEN_STEP) == 0)
  ) else $error("misaligned base address or stride at start");

endmodule

// ==== design/addrgen_trans_tracker.sv ====
`timescale 1ns/100ps
`include "addrgen_defs.svh"

module addrgen_trans_tracker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic                        enable_i,     // consumer takes the address
  input  logic [`ADDRGEN_TRANS_W-1:0] trans_size_i,
  output logic                        step_o,
  output logic                        in_progress_o
);

  logic [`ADDRGEN_TRANS_W-1:0] count_q;  // steps consumed so far
  logic [`ADDRGEN_TRANS_W-1:0] count_nx;
  logic                        in_progress_q;
  logic                        last_step; // this step is the trans_size-th

  assign step_o    = enable_i & in_progress_q;
  assign count_nx  = count_q + 1'b1;
  assign last_step = (count_nx == trans_size_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q       <= '0;
      in_progress_q <= 1'b0;
    end else if (start_i) begin
      count_q       <= '0;
      // zero size ends right away, no step
      in_progress_q <= (trans_size_i != '0);
    end else if (step_o) begin
      count_q <= count_nx;
      if (last_step) begin
        in_progress_q <= 1'b0; // falls on the consuming edge
      end
    end
  end

  assign in_progress_o = in_progress_q;

  // count stays below the size while running, else the end was missed
  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_progress_q |-> (count_q < trans_size_i)
  ) else $error("transaction counter overran trans_size");

endmodule

// ==== design/addrgen_loop_walker.sv ====
`timescale 1ns/100ps
`include "addrgen_defs.svh"

module addrgen_loop_walker (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic                          step_i,
  input  addrgen_reg_pkg::addrgen_cfg_t cfg_i,
  output logic [`ADDRGEN_ADDR_W-1:0]    gen_addr_o,
  output logic                          word_update_o,
  output logic                          line_update_o,
  output logic                          feat_update_o
);

  import addrgen_loop_pkg::*;

  addrgen_pos_t               pos_q;
  addrgen_pos_t               pos_d;
  addrgen_step_e              step_kind;
  logic [`ADDRGEN_CNT_W-1:0]  line_len_m1; // last word index
  logic [`ADDRGEN_CNT_W-1:0]  feat_len_m1; // last line index
  logic [`ADDRGEN_CNT_W-1:0]  roll_m1;     // last feature index
  logic [`ADDRGEN_ADDR_W-1:0] line_stride_ext;
  logic [`ADDRGEN_ADDR_W-1:0] feat_stride_ext;
  logic [`ADDRGEN_ADDR_W-1:0] word_off;

  assign line_len_m1 = cfg_i.line_length - 1'b1;
  assign feat_len_m1 = cfg_i.feat_length - 1'b1;
  assign roll_m1     = cfg_i.feat_roll - 1'b1;

  // sign extended strides, offsets wrap mod 2^32
  assign line_stride_ext =
    {{(`ADDRGEN_ADDR_W-`ADDRGEN_STRIDE_W){cfg_i.line_stride[`ADDRGEN_STRIDE_W-1]}},
     cfg_i.line_stride};
  assign feat_stride_ext =
    {{(`ADDRGEN_ADDR_W-`ADDRGEN_STRIDE_W){cfg_i.feat_stride[`ADDRGEN_STRIDE_W-1]}},
     cfg_i.feat_stride};

  // classify the step starting with the innermost loop
  always_comb begin
    if (!step_i) begin
      step_kind = STEP_IDLE;
    end else if (pos_q.word_idx < line_len_m1) begin
      step_kind = STEP_WORD;
    end else if (pos_q.line_idx < feat_len_m1) begin
      step_kind = STEP_LINE;
    end else if (cfg_i.loop_outer) begin
      // outer mode moves the offset only once the roll count is used up
      step_kind = (pos_q.feat_idx == roll_m1) ? STEP_FEAT_ADV : STEP_FEAT_HOLD;
    end else begin
      // inner mode moves the offset every feature and wraps after the roll
      step_kind = (pos_q.feat_idx < roll_m1) ? STEP_FEAT_ADV : STEP_WRAP;
    end
  end

  // next position
  always_comb begin
    pos_d = pos_q; // idle holds
    case (step_kind)
      STEP_WORD: begin
        pos_d.word_idx = pos_q.word_idx + 1'b1;
      end
      STEP_LINE: begin
        pos_d.word_idx = '0;
        pos_d.line_idx = pos_q.line_idx + 1'b1;
        pos_d.line_off = pos_q.line_off + line_stride_ext;
      end
      STEP_FEAT_ADV: begin
        pos_d.word_idx = '0;
        pos_d.line_idx = '0;
        pos_d.line_off = '0;
        pos_d.feat_off = pos_q.feat_off + feat_stride_ext;
        // outer restarts the roll and inner counts on
        pos_d.feat_idx = cfg_i.loop_outer ? '0 : pos_q.feat_idx + 1'b1;
      end
      STEP_FEAT_HOLD: begin
        pos_d.word_idx = '0;
        pos_d.line_idx = '0;
        pos_d.line_off = '0;
        pos_d.feat_idx = pos_q.feat_idx + 1'b1; // same feature offset again
      end
      STEP_WRAP: begin
        pos_d = '0; // back to base
      end
      default: begin
        pos_d = pos_q;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pos_q <= '0;
    end else if (start_i) begin
      pos_q <= '0; // fresh walk
    end else begin
      pos_q <= pos_d;
    end
  end

  assign word_off   = `ADDRGEN_ADDR_W'(pos_q.word_idx) * `ADDRGEN_ADDR_W'(`ADDRGEN_STEP);
  assign gen_addr_o = cfg_i.base_addr + pos_q.feat_off + pos_q.line_off + word_off;

  // flags in the same cycle as the step
  assign word_update_o = (step_kind != STEP_IDLE);
  assign line_update_o = step_kind inside {STEP_LINE, STEP_FEAT_ADV, STEP_FEAT_HOLD, STEP_WRAP};
  assign feat_update_o = step_kind inside {STEP_FEAT_ADV, STEP_FEAT_HOLD, STEP_WRAP};

  // indices stay inside the configured loop lengths while stepping
  a_idx_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    step_i |-> (pos_q.word_idx <= line_len_m1) && (pos_q.line_idx <= feat_len_m1) &&
               (pos_q.feat_idx <= roll_m1)
  ) else $error("loop index past its configured length");

endmodule

// ==== design/addrgen_top.sv ====
`timescale 1ns/100ps
`include "addrgen_defs.svh"

module addrgen_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // APB3 configuration port
  input  logic                            psel_i,
  input  logic                            penable_i,
  input  logic                            pwrite_i,
  input  logic [`ADDRGEN_APB_AW-1:0]      paddr_i,
  input  logic [`ADDRGEN_ADDR_W-1:0]      pwdata_i,
  output logic [`ADDRGEN_ADDR_W-1:0]      prdata_o,
  output logic                            pready_o,
  output logic                            pslverr_o,
  // consumer side
  input  logic                            enable_i,
  output logic [`ADDRGEN_ADDR_W-1:0]      gen_addr_o,
  output addrgen_loop_pkg::addrgen_flags_t flags_o
);

  import addrgen_reg_pkg::*;

  addrgen_cfg_t cfg;
  logic         start;       // one cycle, from the CTRL write
  logic         step;        // consumed address this cycle
  logic         in_progress;
  logic         word_update;
  logic         line_update;
  logic         feat_update;

  addrgen_apb_regs u_apb_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .in_progress_i (in_progress),
    .cfg_o         (cfg),
    .start_o       (start)
  );

  addrgen_trans_tracker u_trans_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start),
    .enable_i      (enable_i),
    .trans_size_i  (cfg.trans_size),
    .step_o        (step),
    .in_progress_o (in_progress)
  );

  addrgen_loop_walker u_loop_walker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start),
    .step_i        (step),
    .cfg_i         (cfg),
    .gen_addr_o    (gen_addr_o),
    .word_update_o (word_update),
    .line_update_o (line_update),
    .feat_update_o (feat_update)
  );

  // flag bundle for the consumer
  assign flags_o = '{
    word_update: word_update,
    line_update: line_update,
    feat_update: feat_update,
    in_progress: in_progress
  };

endmodule

// ==== tb/tb_addrgen.sv ====
`timescale 1ns/100ps
`include "addrgen_defs.svh"

module tb_addrgen;

  import addrgen_reg_pkg::*;
  import addrgen_loop_pkg::*;

  logic                       clk;
  logic                       rst_n;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`ADDRGEN_APB_AW-1:0] paddr;
  logic [`ADDRGEN_ADDR_W-1:0] pwdata;
  logic [`ADDRGEN_ADDR_W-1:0] prdata;
  logic                       pready;
  logic                       pslverr;
  logic                       enable;
  logic [`ADDRGEN_ADDR_W-1:0] gen_addr;
  addrgen_flags_t             flags;

  addrgen_cfg_t               m_cfg;     // config of the current transfer
  addrgen_pos_t               m_pos;     // model position
  int                         consumed;  // steps taken by the consumer
  addrgen_pos_t               nxt_pos;
  logic [2:0]                 exp_flags; // word, line, feat
  logic [`ADDRGEN_ADDR_W-1:0] exp_addr;

  addrgen_top addrgen_top_i (
    .clk_i(clk), .rst_ni(rst_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .enable_i(enable), .gen_addr_o(gen_addr), .flags_o(flags)
  );

  always #5 clk = ~clk; // 10 ns period

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // base plus feature, line and word offsets
  function automatic logic [31:0] expected_addr(input addrgen_pos_t p, input addrgen_cfg_t c);
    return c.base_addr + p.feat_off + p.line_off + 32'(p.word_idx) * `ADDRGEN_STEP;
  endfunction

  // one consumed step of the loop nest with word/line/feat updates in fl
  function automatic addrgen_pos_t ref_step(input addrgen_pos_t p, input addrgen_cfg_t c,
                                            output logic [2:0] fl);
    addrgen_pos_t n;
    n = p;
    if (int'(p.word_idx) < int'(c.line_length) - 1) begin
      n.word_idx = p.word_idx + 10'd1;
      fl = 3'b100;
    end else if (int'(p.line_idx) < int'(c.feat_length) - 1) begin
      n.word_idx = '0;
      n.line_idx = p.line_idx + 10'd1;
      n.line_off = p.line_off + sext16(c.line_stride);
      fl = 3'b110;
    end else begin
      fl = 3'b111;
      n.word_idx = '0; // every feature kind restarts the line
      n.line_idx = '0;
      n.line_off = '0;
      if (c.loop_outer) begin
        if (int'(p.feat_idx) == int'(c.feat_roll) - 1) begin
          n.feat_idx = '0; // roll used up so the offset moves
          n.feat_off = p.feat_off + sext16(c.feat_stride);
        end else begin
          n.feat_idx = p.feat_idx + 10'd1;
        end
      end else if (int'(p.feat_idx) < int'(c.feat_roll) - 1) begin
        n.feat_idx = p.feat_idx + 10'd1;
        n.feat_off = p.feat_off + sext16(c.feat_stride);
      end else begin
        n = '0; // inner wrap back to base
      end
    end
    return n;
  endfunction

  // compare against the model on every edge of a transfer
  always @(posedge clk) begin
    if (flags.in_progress) begin
      exp_addr = expected_addr(m_pos, m_cfg);
      if (enable) begin
        nxt_pos = ref_step(m_pos, m_cfg, exp_flags);
      end else begin
        nxt_pos   = m_pos; // back-pressure holds everything
        exp_flags = 3'b000;
      end
      assert (gen_addr == exp_addr) else stop_run($sformatf(
        "FAIL %0t: address %h, expected %h", $time, gen_addr, exp_addr));
      assert ({flags.word_update, flags.line_update, flags.feat_update} == exp_flags)
        else stop_run($sformatf("FAIL %0t: flags %b, expected %b", $time,
                      {flags.word_update, flags.line_update, flags.feat_update}, exp_flags));
      assert (consumed < int'(m_cfg.trans_size)) else stop_run($sformatf(
        "FAIL %0t: still in progress after %0d steps", $time, consumed));
      if (enable) consumed++;
      m_pos = nxt_pos;
    end else begin
      assert ({flags.word_update, flags.line_update, flags.feat_update} == 3'b000)
        else stop_run($sformatf("FAIL %0t: update flag while idle", $time));
    end
  end

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data, input logic err);
    psel = 1'b1; // setup phase
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk); #1;
    penable = 1'b1;
    #1; // response settles
    assert (pready) else stop_run("pready low in an APB access phase");
    assert (pslverr == err) else stop_run($sformatf(
      "FAIL %0t: pslverr %0b on write to %h", $time, pslverr, addr));
    @(posedge clk); #1; // access edge
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic err, output logic [31:0] data);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk); #1;
    penable = 1'b1;
    #1;
    assert (pready) else stop_run("pready low in an APB access phase");
    assert (pslverr == err) else stop_run($sformatf(
      "FAIL %0t: pslverr %0b on read of %h", $time, pslverr, addr));
    data = prdata;
    @(posedge clk); #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    read_reg(addr, 1'b0, data);
    assert (data == exp) else stop_run($sformatf(
      "FAIL %0t: register %h read %h, expected %h", $time, addr, data, exp));
  endtask

  task automatic program_cfg(input addrgen_cfg_t c);
    write_reg(REG_BASE, c.base_addr, 1'b0);
    write_reg(REG_TRANS, 32'(c.trans_size), 1'b0);
    write_reg(REG_LINE_STRIDE, sext16(c.line_stride), 1'b0);
    write_reg(REG_LINE_LEN, 32'(c.line_length), 1'b0);
    write_reg(REG_FEAT_STRIDE, sext16(c.feat_stride), 1'b0);
    write_reg(REG_FEAT_LEN, 32'(c.feat_length), 1'b0);
    write_reg(REG_FEAT_ROLL, 32'(c.feat_roll), 1'b0);
    m_cfg = c;
  endtask

  // lengths 1..4 and aligned strides of either sign over about two full rolls
  function automatic addrgen_cfg_t random_cfg(input logic outer);
    addrgen_cfg_t c;
    c.base_addr   = $urandom() & 32'hFFFF_FFFC;
    c.line_length = 10'($urandom_range(1, 4));
    c.feat_length = 10'($urandom_range(1, 4));
    c.feat_roll   = 10'($urandom_range(1, 4));
    c.line_stride = 16'((int'($urandom_range(0, 32)) - 16) * `ADDRGEN_STEP);
    c.feat_stride = 16'((int'($urandom_range(0, 64)) - 32) * `ADDRGEN_STEP);
    c.loop_outer  = outer;
    c.trans_size  = 16'(int'(c.line_length) * int'(c.feat_length) * int'(c.feat_roll) * 2
                        + int'($urandom_range(0, 5)));
    return c;
  endfunction

  // start and consume until in_progress drops with gap_pct percent idle cycles
  task automatic run_transfer(input int gap_pct);
    int cycles;
    m_pos = '0;
    consumed = 0;
    write_reg(REG_CTRL, 32'h2 | 32'(m_cfg.loop_outer), 1'b0);
    // in_progress is registered on the access edge of the start write
    assert (flags.in_progress) else stop_run($sformatf(
      "FAIL %0t: in_progress not set one cycle after the start command", $time));
    check_reg(REG_STATUS, 32'h1); // consumer idle meanwhile
    cycles = 0;
    while (flags.in_progress) begin
      enable = (int'($urandom_range(0, 99)) >= gap_pct);
      @(posedge clk); #1;
      cycles++;
      if (cycles > 20 * int'(m_cfg.trans_size) + 100) begin
        stop_run("transfer did not finish in time");
      end
    end
    enable = 1'b0;
    assert (consumed == int'(m_cfg.trans_size)) else stop_run($sformatf(
      "FAIL %0t: %0d steps consumed, expected %0d", $time, consumed, m_cfg.trans_size));
    check_reg(REG_STATUS, 32'h0);
  endtask

  initial begin : main
    logic [7:0]   offs[8];
    logic [31:0]  vals[8];
    logic [31:0]  dummy;
    addrgen_cfg_t c;
    void'($urandom(32'h4afdab05));
    clk = 1'b0;
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    enable = 1'b0;
    m_cfg = '0;
    m_pos = '0;
    consumed = 0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    // register readback and error response
    assert (flags == '0) else stop_run($sformatf("FAIL %0t: flags %b after reset", $time, flags));
    check_reg(REG_STATUS, 32'h0);
    offs = '{REG_BASE, REG_TRANS, REG_LINE_STRIDE, REG_LINE_LEN,
             REG_FEAT_STRIDE, REG_FEAT_LEN, REG_FEAT_ROLL, REG_CTRL};
    vals = '{$urandom(), 32'($urandom_range(0, 65535)), sext16(16'($urandom())),
             32'($urandom_range(1, 1023)), sext16(16'($urandom())),
             32'($urandom_range(1, 1023)), 32'($urandom_range(1, 1023)), 32'h1};
    for (int i = 0; i < 8; i++) write_reg(offs[i], vals[i], 1'b0);
    for (int i = 0; i < 8; i++) check_reg(offs[i], vals[i]);
    read_reg(8'h24, 1'b1, dummy); // hole in the map
    write_reg(REG_STATUS, 32'h1, 1'b1);
    check_reg(REG_STATUS, 32'h0);

    // single loop of 8 words
    c = '0;
    c.base_addr = 32'h0000_1000;
    c.trans_size = 16'd8;
    c.line_length = 10'd8;
    c.feat_length = 10'd1;
    c.feat_roll = 10'd1;
    c.loop_outer = 1'b1;
    program_cfg(c);
    run_transfer(0);

    for (int i = 0; i < 4; i++) begin // outer mode
      program_cfg(random_cfg(1'b1));
      run_transfer(0);
    end
    for (int i = 0; i < 4; i++) begin // inner mode with wrap
      program_cfg(random_cfg(1'b0));
      run_transfer(0);
    end
    for (int i = 0; i < 4; i++) begin // consumer stalls
      program_cfg(random_cfg(i[0]));
      run_transfer(40);
    end

    $display("No errors");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
design/addrgen_reg_pkg.sv
design/addrgen_loop_pkg.sv
design/addrgen_apb_regs.sv
design/addrgen_trans_tracker.sv
design/addrgen_loop_walker.sv
design/addrgen_top.sv
tb/tb_addrgen.sv

// ==== Makefile ====
TOP := tb_addrgen

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
